// File: flist.f
source/clock_pkg.sv
source/tick_gen.sv
source/key_sync.sv
source/clock_ctrl.sv
source/time_counter.sv
source/alarm_unit.sv
source/seg_display.sv
source/watch_top.sv
sim/tb_clk_gen.sv
sim/tb_watch.sv

// File: Makefile
TOP = tb_watch

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): flist.f $(wildcard source/*.sv sim/*.sv)
	verilator --binary --timing -f flist.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -Wall -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: sim/tb_watch.sv
`timescale 1ns/1ps

module tb_watch;

	import clock_pkg::*;

	localparam int TPS = 400;	// cycles per second in simulation

	logic clk;
	logic rst_n;
	logic [NUM_BTNS-1:0] btn_n;
	seg_t seg;
	logic [NUM_DIGITS-1:0] digit_en_n;
	logic alarm;
	int cyc = 0;	// rising edges since reset release
	int seed = 3540;
	int digit_val [NUM_DIGITS];
	mode_t m_mode = MODE_CLOCK;
	pos_t m_pos = POS_SEC;
	logic m_en = 1'b0;
	int base_secs = 0;	// time of day at the last mode change
	int base_ticks = 0;
	int alarm_secs = 0;
	logic latched;

	tb_clk_gen u_clk_gen (.o_clk(clk), .o_rst_n(rst_n));

	watch_top #(.TICKS_PER_SEC(TPS), .SCAN_DIV(4), .SAMPLE_DIV(8)) watch_top_inst (
		.clk(clk), .rst_n(rst_n), .i_btn_n(btn_n),
		.o_seg(seg), .o_digit_en_n(digit_en_n), .o_alarm(alarm)
	);

	always @(posedge clk) begin
		if (rst_n) begin
			cyc <= cyc + 1;
		end
	end

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------
	function automatic int model_secs();
		if (m_mode == MODE_SETUP) begin
			return base_secs;	// frozen
		end
		return (base_secs + cyc / TPS - base_ticks) % 86400;
	endfunction

	function automatic int field_of(int total, int f);
		case (f)
			0: return total % 60;
			1: return (total / 60) % 60;
			default: return total / 3600;
		endcase
	endfunction

	// one field up without carry into the next
	function automatic int bump_field(int total, pos_t p);
		int lim;
		int step;
		lim = (p == POS_HR) ? 24 : 60;
		step = (p == POS_SEC) ? 1 : ((p == POS_MIN) ? 60 : 3600);
		if (field_of(total, int'(p)) == lim - 1) begin
			return total - (lim - 1) * step;
		end
		return total + step;
	endfunction

	function automatic int seg_value(seg_t s);
		case (s)
			7'b111_1110: return 0;
			7'b011_0000: return 1;
			7'b110_1101: return 2;
			7'b111_1001: return 3;
			7'b011_0011: return 4;
			7'b101_1011: return 5;
			7'b101_1111: return 6;
			7'b111_0000: return 7;
			7'b111_1111: return 8;
			7'b111_1011: return 9;
			default: return -1;
		endcase
	endfunction

	function automatic int rand_count();
		return $unsigned($random(seed)) % 71;
	endfunction

	// --------------------------------------------------
	// checks
	// --------------------------------------------------
	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_fields(input string what, input field_t got, input field_t exp);
		if (got !== exp) begin
			fail_now($sformatf("ERR @%0t: %s shows %0d, expected %0d", $time, what, got, exp));
		end
	endtask

	task automatic check_alarm(input logic got, input logic exp);
		if (got !== exp) begin
			fail_now($sformatf("ERR @%0t: o_alarm is %b, expected %b", $time, got, exp));
		end
	endtask

	task automatic wait_phase(input int phase);
		int guard;
		guard = 0;
		do begin
			@(posedge clk);
			#1;
			guard++;
			if (guard > 2 * TPS) begin
				fail_now("timeout: never reached the wanted point within a second");
			end
		end while (cyc % TPS != phase);
	endtask

	task automatic scan_digits();
		logic [NUM_DIGITS-1:0] seen;
		int guard;
		seen = '0;
		guard = 0;
		while (seen != '1) begin
			@(negedge clk);
			guard++;
			if (guard > 100) begin
				fail_now("timeout: the digit scan did not enable every digit");
			end
			for (int i = 0; i < NUM_DIGITS; i++) begin
				if (digit_en_n == ~(NUM_DIGITS'(1) << i)) begin
					digit_val[i] = seg_value(seg);
					seen[i] = 1'b1;
				end
			end
		end
	endtask

	task automatic check_display();
		int prev;
		int tries;
		int t;
		wait_phase(200);	// well clear of a second boundary
		scan_digits();
		tries = 0;
		do begin
			prev = digit_val[1] * 10 + digit_val[0];
			scan_digits();
			tries++;
			if (tries > 4) begin
				fail_now("timeout: the seconds digits never read the same twice");
			end
		end while (digit_val[1] * 10 + digit_val[0] != prev);
		foreach (digit_val[i]) begin
			if (digit_val[i] < 0) begin
				fail_now($sformatf("ERR @%0t: digit %0d shows no decimal digit", $time, i));
			end
		end
		t = (m_mode == MODE_ALARM) ? alarm_secs : model_secs();
		check_fields("hours", field_t'(digit_val[5] * 10 + digit_val[4]),
			field_t'(field_of(t, 2)));
		check_fields("minutes", field_t'(digit_val[3] * 10 + digit_val[2]),
			field_t'(field_of(t, 1)));
		check_fields("seconds", field_t'(digit_val[1] * 10 + digit_val[0]),
			field_t'(field_of(t, 0)));
	endtask

	// --------------------------------------------------
	// buttons
	// --------------------------------------------------
	task automatic press_button(input int btn);
		if (btn == BTN_MODE || btn == BTN_ALM) begin
			wait_phase(100);	// keeps the change away from a tick
		end else begin
			@(posedge clk);
			#1;
		end
		btn_n = ~(NUM_BTNS'(1) << btn);
		repeat (40) @(posedge clk);
		#1;
		btn_n = '1;
		repeat (40) @(posedge clk);
		#1;
		case (btn)
			BTN_MODE: begin
				base_secs = model_secs();
				base_ticks = cyc / TPS;
				m_mode = (m_mode == MODE_CLOCK) ? MODE_SETUP :
					((m_mode == MODE_SETUP) ? MODE_ALARM : MODE_CLOCK);
			end
			BTN_POS: begin
				m_pos = (m_pos == POS_SEC) ? POS_MIN :
					((m_pos == POS_MIN) ? POS_HR : POS_SEC);
			end
			BTN_INC: begin
				if (m_mode == MODE_SETUP) begin
					base_secs = bump_field(base_secs, m_pos);
				end else if (m_mode == MODE_ALARM) begin
					alarm_secs = bump_field(alarm_secs, m_pos);
				end
			end
			default: m_en = !m_en;
		endcase
	endtask

	// walks sec, min, hr and ends back on sec
	task automatic inc_fields(input int n_sec, input int n_min, input int n_hr);
		repeat (n_sec) press_button(BTN_INC);
		press_button(BTN_POS);
		repeat (n_min) press_button(BTN_INC);
		press_button(BTN_POS);
		repeat (n_hr) press_button(BTN_INC);
		press_button(BTN_POS);
	endtask

	task automatic set_fields(input int target);
		int cur;
		cur = (m_mode == MODE_ALARM) ? alarm_secs : model_secs();
		inc_fields((field_of(target, 0) - field_of(cur, 0) + 60) % 60,
			(field_of(target, 1) - field_of(cur, 1) + 60) % 60,
			(field_of(target, 2) - field_of(cur, 2) + 24) % 24);
	endtask

	initial begin
		btn_n = '1;
		check_display();	// reset state
		check_alarm(alarm, 1'b0);

		// preset 00:00:55 and run across the minute
		press_button(BTN_MODE);
		set_fields(55);
		press_button(BTN_MODE);
		press_button(BTN_MODE);
		repeat (8) check_display();

		// random setting with the count frozen
		press_button(BTN_MODE);
		inc_fields(rand_count(), rand_count(), rand_count());
		check_display();
		repeat (3 * TPS) @(posedge clk);
		check_display();

		// alarm setting while the time runs on
		press_button(BTN_MODE);
		inc_fields(rand_count(), rand_count(), rand_count());
		check_display();
		press_button(BTN_MODE);
		repeat (3) check_display();

		// time set 5 s short of the alarm so two ticks pass before enable
		press_button(BTN_MODE);
		set_fields((alarm_secs + 86400 - 5) % 86400);
		press_button(BTN_MODE);
		press_button(BTN_MODE);
		press_button(BTN_ALM);
		latched = 1'b0;
		repeat (8) begin
			check_display();
			if (m_en && model_secs() == alarm_secs) begin
				latched = 1'b1;
			end
			check_alarm(alarm, latched);
		end
		if (!latched) begin
			fail_now("the alarm time was never reached");
		end
		press_button(BTN_ALM);
		if (!m_en) begin
			latched = 1'b0;
		end
		check_alarm(alarm, latched);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: sim/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
	output logic o_clk,
	output logic o_rst_n
);

	initial begin
		o_clk = 1'b0;
		forever #5 o_clk = ~o_clk;	// 10 ns period
	end

	// reset held over the first three rising edges
	initial begin
		o_rst_n = 1'b0;
		repeat (3) @(posedge o_clk);
		#1;
		o_rst_n = 1'b1;
	end

endmodule

// File: source/watch_top.sv
`timescale 1ns/1ps

module watch_top #(
	parameter int TICKS_PER_SEC = 50_000_000,
	parameter int SCAN_DIV = 5_000,
	parameter int SAMPLE_DIV = 500_000
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic [clock_pkg::NUM_BTNS-1:0]   i_btn_n,
	output clock_pkg::seg_t                  o_seg,
	output logic [clock_pkg::NUM_DIGITS-1:0] o_digit_en_n,
	output logic                             o_alarm
);

	import clock_pkg::*;

	logic sec_tick;
	logic scan_tick;
	logic sample_tick;
	logic [NUM_BTNS-1:0] press;
	mode_t mode;
	pos_t pos;
	logic alarm_en;
	logic inc_time;
	logic inc_alarm;
	field_t sec, min, hr;
	field_t al_sec, al_min, al_hr;

	// --------------------------------------------------
	// enable strobes
	// --------------------------------------------------
	tick_gen #(.DIV(TICKS_PER_SEC)) u_sec_tick (.clk(clk), .rst_n(rst_n), .o_tick(sec_tick));
	tick_gen #(.DIV(SCAN_DIV)) u_scan_tick (.clk(clk), .rst_n(rst_n), .o_tick(scan_tick));
	tick_gen #(.DIV(SAMPLE_DIV)) u_sample_tick (.clk(clk), .rst_n(rst_n), .o_tick(sample_tick));

	key_sync u_key_sync (
		.clk(clk), .rst_n(rst_n), .i_sample(sample_tick), .i_btn_n(i_btn_n), .o_press(press)
	);

	clock_ctrl u_clock_ctrl (
		.clk(clk), .rst_n(rst_n), .i_press(press), .o_mode(mode), .o_pos(pos),
		.o_alarm_en(alarm_en), .o_inc_time(inc_time), .o_inc_alarm(inc_alarm)
	);

	time_counter u_time_counter (
		.clk(clk), .rst_n(rst_n), .i_sec_tick(sec_tick), .i_mode(mode), .i_pos(pos),
		.i_inc(inc_time), .o_sec(sec), .o_min(min), .o_hr(hr)
	);

	alarm_unit u_alarm_unit (
		.clk(clk), .rst_n(rst_n), .i_inc(inc_alarm), .i_pos(pos), .i_alarm_en(alarm_en),
		.i_sec(sec), .i_min(min), .i_hr(hr),
		.o_al_sec(al_sec), .o_al_min(al_min), .o_al_hr(al_hr), .o_alarm(o_alarm)
	);

	seg_display u_seg_display (
		.clk(clk), .rst_n(rst_n), .i_scan_tick(scan_tick), .i_mode(mode),
		.i_sec(sec), .i_min(min), .i_hr(hr),
		.i_al_sec(al_sec), .i_al_min(al_min), .i_al_hr(al_hr),
		.o_seg(o_seg), .o_digit_en_n(o_digit_en_n)
	);

endmodule

// File: source/seg_display.sv
`timescale 1ns/1ps

module seg_display (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             i_scan_tick,
	input  clock_pkg::mode_t                 i_mode,
	input  clock_pkg::field_t                i_sec,
	input  clock_pkg::field_t                i_min,
	input  clock_pkg::field_t                i_hr,
	input  clock_pkg::field_t                i_al_sec,
	input  clock_pkg::field_t                i_al_min,
	input  clock_pkg::field_t                i_al_hr,
	output clock_pkg::seg_t                  o_seg,
	output logic [clock_pkg::NUM_DIGITS-1:0] o_digit_en_n
);

	import clock_pkg::*;

	localparam int IDX_W = $clog2(NUM_DIGITS);

	logic [IDX_W-1:0] idx;
	logic [IDX_W-1:0] idx_nxt;
	field_t cur_field;
	logic [3:0] cur_digit;

	function automatic seg_t seg_decode(logic [3:0] num);
		case (num)
			4'd0:    return 7'b111_1110;
			4'd1:    return 7'b011_0000;
			4'd2:    return 7'b110_1101;
			4'd3:    return 7'b111_1001;
			4'd4:    return 7'b011_0011;
			4'd5:    return 7'b101_1011;
			4'd6:    return 7'b101_1111;
			4'd7:    return 7'b111_0000;
			4'd8:    return 7'b111_1111;
			4'd9:    return 7'b111_1011;
			default: return 7'b000_0000;	// blank
		endcase
	endfunction

	// --------------------------------------------------
	// digit select and decimal split
	// --------------------------------------------------
	always_comb begin
		idx_nxt = idx;
		if (i_scan_tick) begin
			idx_nxt = (idx == IDX_W'(NUM_DIGITS - 1)) ? '0 : idx + 1'b1;
		end
		// digit pairs in order sec, min, hr
		case (idx_nxt[IDX_W-1:1])
			2'd0:    cur_field = (i_mode == MODE_ALARM) ? i_al_sec : i_sec;
			2'd1:    cur_field = (i_mode == MODE_ALARM) ? i_al_min : i_min;
			default: cur_field = (i_mode == MODE_ALARM) ? i_al_hr : i_hr;
		endcase
		cur_digit = idx_nxt[0] ? 4'(cur_field / 10) : 4'(cur_field % 10);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx <= '0;
			o_seg <= '0;
			o_digit_en_n <= ~NUM_DIGITS'(1);	// digit 0
		end else begin
			idx <= idx_nxt;
			o_seg <= seg_decode(cur_digit);
			o_digit_en_n <= ~(NUM_DIGITS'(1) << idx_nxt);
		end
	end

endmodule

// File: source/alarm_unit.sv
`timescale 1ns/1ps

module alarm_unit (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              i_inc,
	input  clock_pkg::pos_t   i_pos,
	input  logic              i_alarm_en,
	input  clock_pkg::field_t i_sec,
	input  clock_pkg::field_t i_min,
	input  clock_pkg::field_t i_hr,
	output clock_pkg::field_t o_al_sec,
	output clock_pkg::field_t o_al_min,
	output clock_pkg::field_t o_al_hr,
	output logic              o_alarm
);

	import clock_pkg::*;

	logic match;

	// --------------------------------------------------
	// alarm time, set per field
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_al_sec <= '0;
			o_al_min <= '0;
			o_al_hr <= '0;
		end else if (i_inc) begin
			case (i_pos)
				POS_SEC: o_al_sec <= field_inc(o_al_sec, SEC_MAX);
				POS_MIN: o_al_min <= field_inc(o_al_min, SEC_MAX);
				POS_HR:  o_al_hr <= field_inc(o_al_hr, HR_MAX);
				default: o_al_sec <= o_al_sec;
			endcase
		end
	end

	assign match = (i_sec == o_al_sec) && (i_min == o_al_min) && (i_hr == o_al_hr);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm <= 1'b0;
		end else if (!i_alarm_en) begin
			o_alarm <= 1'b0;	// only disabling clears it
		end else if (match) begin
			o_alarm <= 1'b1;
		end
	end

endmodule

// File: source/time_counter.sv
`timescale 1ns/1ps

module time_counter (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              i_sec_tick,
	input  clock_pkg::mode_t  i_mode,
	input  clock_pkg::pos_t   i_pos,
	input  logic              i_inc,
	output clock_pkg::field_t o_sec,
	output clock_pkg::field_t o_min,
	output clock_pkg::field_t o_hr
);

	import clock_pkg::*;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_sec <= '0;
			o_min <= '0;
			o_hr <= '0;
		end else if (i_mode == MODE_SETUP) begin
			// count frozen, one field at a time, no carry
			if (i_inc) begin
				case (i_pos)
					POS_SEC: o_sec <= field_inc(o_sec, SEC_MAX);
					POS_MIN: o_min <= field_inc(o_min, SEC_MAX);
					POS_HR:  o_hr <= field_inc(o_hr, HR_MAX);
					default: o_sec <= o_sec;
				endcase
			end
		end else if (i_sec_tick) begin
			o_sec <= field_inc(o_sec, SEC_MAX);
			if (o_sec == SEC_MAX) begin
				o_min <= field_inc(o_min, SEC_MAX);	// carry into minutes
				if (o_min == SEC_MAX) begin
					o_hr <= field_inc(o_hr, HR_MAX);
				end
			end
		end
	end

endmodule

// File: source/clock_ctrl.sv
`timescale 1ns/1ps

module clock_ctrl (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [clock_pkg::NUM_BTNS-1:0] i_press,
	output clock_pkg::mode_t               o_mode,
	output clock_pkg::pos_t                o_pos,
	output logic                           o_alarm_en,
	output logic                           o_inc_time,
	output logic                           o_inc_alarm
);

	import clock_pkg::*;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode <= MODE_CLOCK;
			o_pos <= POS_SEC;
			o_alarm_en <= 1'b0;
		end else begin
			if (i_press[BTN_MODE]) begin
				case (o_mode)
					MODE_CLOCK: o_mode <= MODE_SETUP;
					MODE_SETUP: o_mode <= MODE_ALARM;
					default:    o_mode <= MODE_CLOCK;
				endcase
			end
			if (i_press[BTN_POS]) begin
				case (o_pos)
					POS_SEC: o_pos <= POS_MIN;
					POS_MIN: o_pos <= POS_HR;
					default: o_pos <= POS_SEC;
				endcase
			end
			if (i_press[BTN_ALM]) begin
				o_alarm_en <= ~o_alarm_en;
			end
		end
	end

	// --------------------------------------------------
	// increment routing, dropped in clock mode
	// --------------------------------------------------
	assign o_inc_time = i_press[BTN_INC] && (o_mode == MODE_SETUP);
	assign o_inc_alarm = i_press[BTN_INC] && (o_mode == MODE_ALARM);

endmodule

// File: source/key_sync.sv
`timescale 1ns/1ps

module key_sync (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           i_sample,
	input  logic [clock_pkg::NUM_BTNS-1:0] i_btn_n,
	output logic [clock_pkg::NUM_BTNS-1:0] o_press
);

	import clock_pkg::*;

	logic [NUM_BTNS-1:0] sync_q1;	// 1 = pressed
	logic [NUM_BTNS-1:0] sync_q2;
	logic [NUM_BTNS-1:0] hist_new;	// last sample
	logic [NUM_BTNS-1:0] hist_old;	// the one before

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync_q1 <= '0;
			sync_q2 <= '0;
			hist_new <= '0;
			hist_old <= '0;
			o_press <= '0;
		end else begin
			sync_q1 <= ~i_btn_n;
			sync_q2 <= sync_q1;
			o_press <= '0;
			if (i_sample) begin
				hist_new <= sync_q2;
				hist_old <= hist_new;
				// released, pressed, pressed
				o_press <= sync_q2 & hist_new & ~hist_old;
			end
		end
	end

endmodule

// File: source/tick_gen.sv
`timescale 1ns/1ps

module tick_gen #(
	parameter int DIV = 2
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);

	localparam int CNT_W = $clog2(DIV);

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (cnt == CNT_W'(DIV - 1)) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	assign o_tick = (cnt == CNT_W'(DIV - 1));	// last count of the period

endmodule

// File: source/clock_pkg.sv
package clock_pkg;

	// --------------------------------------------------
	// modes and setting positions
	// --------------------------------------------------
	typedef enum logic [1:0] {
		MODE_CLOCK,
		MODE_SETUP,
		MODE_ALARM
	} mode_t;

	typedef enum logic [1:0] {
		POS_SEC,
		POS_MIN,
		POS_HR
	} pos_t;

	typedef logic [5:0] field_t;	// one of sec, min, hr
	typedef logic [6:0] seg_t;	// {a, b, c, d, e, f, g}

	localparam int NUM_DIGITS = 6;
	localparam field_t SEC_MAX = 6'd59;	// minutes share it
	localparam field_t HR_MAX = 6'd23;

	// button bus indices
	localparam int BTN_MODE = 0;
	localparam int BTN_POS = 1;
	localparam int BTN_INC = 2;
	localparam int BTN_ALM = 3;
	localparam int NUM_BTNS = 4;

	// +1 with wrap to zero past the limit
	function automatic field_t field_inc(field_t val, field_t lim);
		return (val >= lim) ? 6'd0 : val + 6'd1;
	endfunction

endpackage
